/* source/video_gray_pkg.sv */
package video_gray_pkg;

    // Bits per colour field of one RGB444 pixel
    localparam int RSIZE = 4;
    localparam int GSIZE = 4;
    localparam int BSIZE = 4;

    // One pixel packs red in the high bits, then green, then blue
    localparam int RGB_SIZE = RSIZE + GSIZE + BSIZE;

    // The gray value is the top nibble of the 12-bit weighted sum
    localparam int GRAY_SIZE = 4;

    // Pixels carried side by side in one beat
    // This is also the number of converter lanes
    localparam int PIXELS_PER_BEAT = 4;

    // Pixel i sits at bits RGB_SIZE*i and up
    localparam int BEAT_SIZE = RGB_SIZE * PIXELS_PER_BEAT;

    // Luminosity weights scaled by 256
    // Red is 0.21, green 0.72 and blue 0.07 of the luminance
    localparam logic [7:0] RW = 8'd53;
    localparam logic [7:0] GW = 8'd184;
    localparam logic [7:0] BW = 8'd18;

    // The weights add up to 255, so a full-scale pixel still fits in 12 bits
    // 15 * 255 = 3825, which keeps the sum below 4096

endpackage

/* source/video_data_pipeline.sv */
`timescale 1ns/100ps

module video_data_pipeline
    import video_gray_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                in_vld,
    output logic                in_rdy,
    input  logic [RGB_SIZE-1:0] in_data,
    output logic                out_vld,
    input  logic                out_rdy,
    output logic [RGB_SIZE-1:0] out_data
);

    // The stage can take a word when it is empty
    // It can also take one when the held word leaves in this same cycle
    assign in_rdy = !out_vld || out_rdy;

    // Valid bit of the single register slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_vld <= 1'b0;
        end else if (in_rdy) begin
            // A new word replaces the leaving one, or the slot goes empty
            out_vld <= in_vld;
        end
    end

    // The payload only moves on an accepted transfer
    // Otherwise the word stays put while the consumer stalls
    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            out_data <= in_data;
        end
    end

endmodule

/* source/video_rgb2gray_gen.sv */
`timescale 1ns/100ps

module video_rgb2gray_gen
    import video_gray_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                rgb_in_vld,
    output logic                rgb_in_rdy,
    input  logic [RGB_SIZE-1:0] rgb_in,
    output logic                rgb_out_vld,
    input  logic                rgb_out_rdy,
    output logic [RGB_SIZE-1:0] rgb_out
);

    // Colour fields of the pixel held in stage 0
    logic [RSIZE-1:0]     s0_r;
    logic [GSIZE-1:0]     s0_g;
    logic [BSIZE-1:0]     s0_b;

    // Handshake and data between the two stages
    logic                 s0_vld;
    logic                 s0_rdy;
    logic [RGB_SIZE-1:0]  s0_data;

    // Weighted terms and their sum, all carried at full pixel width
    logic [RGB_SIZE-1:0]  r_term;
    logic [RGB_SIZE-1:0]  g_term;
    logic [RGB_SIZE-1:0]  b_term;
    logic [RGB_SIZE-1:0]  s0_sum;

    // Registered sum and the gray nibble taken from it
    logic [RGB_SIZE-1:0]  s1_sum;
    logic [GRAY_SIZE-1:0] gray;

    // Stage 0 registers the incoming pixel
    video_data_pipeline u_stage_0 (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (rgb_in_vld),
        .in_rdy   (rgb_in_rdy),
        .in_data  (rgb_in),
        .out_vld  (s0_vld),
        .out_rdy  (s0_rdy),
        .out_data (s0_data)
    );

    assign {s0_r, s0_g, s0_b} = s0_data;

    // Each term is widened first so the products cannot wrap
    assign r_term = RGB_SIZE'(s0_r) * RGB_SIZE'(RW);
    assign g_term = RGB_SIZE'(s0_g) * RGB_SIZE'(GW);
    assign b_term = RGB_SIZE'(s0_b) * RGB_SIZE'(BW);
    assign s0_sum = r_term + g_term + b_term;

    // Stage 1 registers the weighted sum
    video_data_pipeline u_stage_1 (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (s0_vld),
        .in_rdy   (s0_rdy),
        .in_data  (s0_sum),
        .out_vld  (rgb_out_vld),
        .out_rdy  (rgb_out_rdy),
        .out_data (s1_sum)
    );

    // Dividing by 256 keeps the top nibble of the sum
    assign gray = s1_sum[RGB_SIZE-1 -: GRAY_SIZE];

    // Gray goes out in the red, green and blue fields alike
    assign rgb_out = {gray, gray, gray};

endmodule

/* source/video_beat_fork.sv */
`timescale 1ns/100ps

module video_beat_fork
    import video_gray_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_vld,
    output logic                       in_rdy,
    output logic [PIXELS_PER_BEAT-1:0] lane_in_vld,
    input  logic [PIXELS_PER_BEAT-1:0] lane_in_rdy
);

    // One flag per lane, set once that lane has taken its pixel of the current beat
    logic [PIXELS_PER_BEAT-1:0] done;

    // Lanes that take their pixel in this cycle
    logic [PIXELS_PER_BEAT-1:0] take;

    // A lane sees the beat only until it has accepted its pixel
    assign lane_in_vld = {PIXELS_PER_BEAT{in_vld}} & ~done;

    assign take = lane_in_vld & lane_in_rdy;

    // The beat is complete once each lane is either ready now or already served
    // This does not look at in_vld, so the upstream ready has no loop through valid
    assign in_rdy = &(lane_in_rdy | done);

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else if (in_vld && in_rdy) begin
            // The whole beat has gone out, so the next one starts clean
            done <= '0;
        end else begin
            // Remember early takers so they are not handed the same pixel twice
            done <= done | take;
        end
    end

endmodule

/* source/video_beat_join.sv */
`timescale 1ns/100ps

module video_beat_join
    import video_gray_pkg::*;
(
    input  logic [PIXELS_PER_BEAT-1:0]               lane_out_vld,
    output logic [PIXELS_PER_BEAT-1:0]               lane_out_rdy,
    input  logic [PIXELS_PER_BEAT-1:0][RGB_SIZE-1:0] lane_out_data,
    output logic                                     out_vld,
    input  logic                                     out_rdy,
    output logic [BEAT_SIZE-1:0]                     out_data
);

    // An output beat exists only when every lane holds a result
    assign out_vld = &lane_out_vld;

    // All lanes are released together, so the four pixels leave as one beat
    // A lane that finished early keeps waiting for the slower ones
    assign lane_out_rdy = {PIXELS_PER_BEAT{out_vld && out_rdy}};

    // Lane i fills pixel slot i of the beat
    always_comb begin
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            out_data[RGB_SIZE*i +: RGB_SIZE] = lane_out_data[i];
        end
    end

endmodule

/* source/video_gray_path.sv */
`timescale 1ns/100ps

module video_gray_path
    import video_gray_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_vld,
    output logic                 in_rdy,
    input  logic [BEAT_SIZE-1:0] in_data,
    output logic                 out_vld,
    input  logic                 out_rdy,
    output logic [BEAT_SIZE-1:0] out_data
);

    // Fork side of each lane
    logic [PIXELS_PER_BEAT-1:0]               lane_in_vld;
    logic [PIXELS_PER_BEAT-1:0]               lane_in_rdy;

    // Join side of each lane
    logic [PIXELS_PER_BEAT-1:0]               lane_out_vld;
    logic [PIXELS_PER_BEAT-1:0]               lane_out_rdy;
    logic [PIXELS_PER_BEAT-1:0][RGB_SIZE-1:0] lane_out_data;

    // Splits the input handshake across the lanes without adding latency
    video_beat_fork u_fork (
        .clk         (clk),
        .rst         (rst),
        .in_vld      (in_vld),
        .in_rdy      (in_rdy),
        .lane_in_vld (lane_in_vld),
        .lane_in_rdy (lane_in_rdy)
    );

    // One converter per pixel slot
    // The input slice is stable while the fork holds in_vld, so it goes straight in
    for (genvar i = 0; i < PIXELS_PER_BEAT; i++) begin : g_lane
        video_rgb2gray_gen u_conv (
            .clk         (clk),
            .rst         (rst),
            .rgb_in_vld  (lane_in_vld[i]),
            .rgb_in_rdy  (lane_in_rdy[i]),
            .rgb_in      (in_data[RGB_SIZE*i +: RGB_SIZE]),
            .rgb_out_vld (lane_out_vld[i]),
            .rgb_out_rdy (lane_out_rdy[i]),
            .rgb_out     (lane_out_data[i])
        );
    end

    // Collects the four gray pixels into one output beat
    video_beat_join u_join (
        .lane_out_vld  (lane_out_vld),
        .lane_out_rdy  (lane_out_rdy),
        .lane_out_data (lane_out_data),
        .out_vld       (out_vld),
        .out_rdy       (out_rdy),
        .out_data      (out_data)
    );

endmodule

/* tb/video_gray_path_checker.sv */
`timescale 1ns/100ps

module video_gray_path_checker
    import video_gray_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 in_vld,
    input logic                 in_rdy,
    input logic [BEAT_SIZE-1:0] in_data,
    input logic                 out_vld,
    input logic                 out_rdy,
    input logic [BEAT_SIZE-1:0] out_data
);

    // Count of failed rules, read by the testbench
    int violations = 0;

    // Any cycle spent in reset leaves the output idle
    a_reset_idle: assert property (@(posedge clk) rst |=> !out_vld)
        else begin
            violations = violations + 1;
            $error("out_vld high after a reset cycle");
        end

    // A stalled output beat stays offered and unchanged
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_vld && !out_rdy |=> out_vld && $stable(out_data))
        else begin
            violations = violations + 1;
            $error("output beat dropped or changed while stalled");
        end

    // The input side must also hold its beat until it is taken
    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        in_vld && !in_rdy |=> in_vld && $stable(in_data))
        else begin
            violations = violations + 1;
            $error("input beat dropped or changed while waiting");
        end

endmodule

/* tb/video_gray_path_tb.sv */
`timescale 1ns/100ps

module video_gray_path_tb
    import video_gray_pkg::*;
();

    localparam int NUM_FIXED   = 3;
    localparam int NUM_BEATS   = 24;
    localparam int NUM_TIMEOUT = 200;
    localparam int DRIVE_DELAY = 2;

    logic                 clk;
    logic                 rst;
    logic                 in_vld;
    logic                 in_rdy;
    logic [BEAT_SIZE-1:0] in_data;
    logic                 out_vld;
    logic                 out_rdy;
    logic [BEAT_SIZE-1:0] out_data;

    // Stimulus beats and the gray beats they must turn into
    logic [BEAT_SIZE-1:0] stim_beat [NUM_BEATS];
    logic [BEAT_SIZE-1:0] exp_beat  [NUM_BEATS];

    // Scoreboard of beats in flight, with the cycle each one was accepted
    logic [BEAT_SIZE-1:0] exp_q[$];
    int                   accept_q[$];

    int cycle_cnt = 0;
    int seed = 32'h91b8;
    bit stall_en;
    bit check_latency;

    video_gray_path dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data)
    );

    bind video_gray_path video_gray_path_checker u_checker (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        fail_run($sformatf("MISMATCH at %0t: %s", $time, what));
    endtask

    // Luminosity of one pixel, 53*r + 184*g + 18*b over 256, rounded down
    function automatic logic [RGB_SIZE-1:0] gray_pixel(input logic [RGB_SIZE-1:0] pix);
        int                   r;
        int                   g;
        int                   b;
        int                   lum;
        logic [GRAY_SIZE-1:0] gray;
        r = int'(pix[RGB_SIZE-1 -: RSIZE]);
        g = int'(pix[BSIZE +: GSIZE]);
        b = int'(pix[0 +: BSIZE]);
        lum = (r * int'(RW) + g * int'(GW) + b * int'(BW)) / 256;
        gray = lum[GRAY_SIZE-1:0];
        return {gray, gray, gray};
    endfunction

    function automatic logic [BEAT_SIZE-1:0] gray_beat(input logic [BEAT_SIZE-1:0] beat);
        logic [BEAT_SIZE-1:0] res;
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            res[RGB_SIZE*i +: RGB_SIZE] = gray_pixel(beat[RGB_SIZE*i +: RGB_SIZE]);
        end
        return res;
    endfunction

    task automatic build_table;
        logic [63:0] raw;
        // The corner pixels are black, white, pure red, pure green and pure blue
        stim_beat[0] = {12'h0F0, 12'hF00, 12'hFFF, 12'h000};
        exp_beat[0]  = {12'hAAA, 12'h333, 12'hEEE, 12'h000};
        stim_beat[1] = {12'h00F, 12'h00F, 12'h0F0, 12'hF00};
        exp_beat[1]  = {12'h111, 12'h111, 12'hAAA, 12'h333};
        stim_beat[2] = {12'h888, 12'h123, 12'hFFF, 12'h000};
        exp_beat[2]  = {12'h777, 12'h111, 12'hEEE, 12'h000};
        // The remaining rows are random pixels run through the reference model
        for (int i = NUM_FIXED; i < NUM_BEATS; i++) begin
            raw = {$random(seed), $random(seed)};
            stim_beat[i] = raw[BEAT_SIZE-1:0];
            exp_beat[i] = gray_beat(stim_beat[i]);
        end
    endtask

    task automatic check_output(input logic [BEAT_SIZE-1:0] got);
        logic [BEAT_SIZE-1:0] want;
        int                   accepted_at;
        assert (exp_q.size() > 0) else fail_run("an output beat arrived with none expected");
        want = exp_q.pop_front();
        accepted_at = accept_q.pop_front();
        assert (got === want)
            else report_mismatch($sformatf("out_data %h, expected %h", got, want));
        if (check_latency) begin
            assert (cycle_cnt == accepted_at + 2)
                else report_mismatch($sformatf("latency of %0d cycles, expected 2",
                                               cycle_cnt - accepted_at));
        end
    endtask

    // Each clock cycle samples the handshakes at the edge, then drives after a short delay
    task automatic step(output logic rdy_seen);
        logic                 took_out;
        logic [BEAT_SIZE-1:0] beat_seen;
        @(posedge clk);
        cycle_cnt++;
        rdy_seen = in_rdy;
        took_out = out_vld && out_rdy;
        beat_seen = out_data;
        if (took_out) begin
            check_output(beat_seen);
        end
        #DRIVE_DELAY;
        if (stall_en) begin
            out_rdy = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic send_beat(input int idx);
        logic rdy_seen;
        int   waited;
        int   gap;
        if (stall_en) begin
            // Idle cycles with in_vld low between beats
            gap = $random(seed) & 3;
            for (int i = 0; i < gap; i++) begin
                step(rdy_seen);
            end
        end
        in_vld = 1'b1;
        in_data = stim_beat[idx];
        waited = 0;
        rdy_seen = 1'b0;
        while (!rdy_seen) begin
            step(rdy_seen);
            waited++;
            if (!rdy_seen && waited >= NUM_TIMEOUT) begin
                fail_run("timeout: the DUT never accepted an input beat");
            end
        end
        if (check_latency) begin
            assert (waited == 1) else report_mismatch("in_rdy fell without any back-pressure");
        end
        exp_q.push_back(exp_beat[idx]);
        accept_q.push_back(cycle_cnt);
        in_vld = 1'b0;
    endtask

    // Runs cycles until every expected beat has come out or the timeout is reached
    task automatic drain;
        logic rdy_seen;
        int   waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < NUM_TIMEOUT) begin
            step(rdy_seen);
            waited++;
        end
    endtask

    // The bound checker counts its assertion failures
    always @(negedge clk) begin
        assert (dut0.u_checker.violations == 0)
            else fail_run("the handshake checker flagged a protocol violation");
    end

    initial begin
        logic rdy_seen;
        rst = 1'b1;
        in_vld = 1'b0;
        in_data = '0;
        out_rdy = 1'b1;
        stall_en = 1'b0;
        check_latency = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        assert (out_vld == 1'b0 && in_rdy == 1'b1)
            else report_mismatch("out_vld must be 0 and in_rdy 1 after reset");

        // Back to back beats with out_rdy high, each one exactly 2 cycles through
        check_latency = 1'b1;
        for (int i = 0; i < NUM_BEATS; i++) begin
            send_beat(i);
        end
        drain();
        assert (exp_q.size() == 0)
            else fail_run("timeout: beats of the back to back pass never came out");

        // Same table again with input gaps and random output stalls
        check_latency = 1'b0;
        stall_en = 1'b1;
        for (int i = 0; i < NUM_BEATS; i++) begin
            send_beat(i);
        end
        drain();
        stall_en = 1'b0;
        out_rdy = 1'b1;

        // A few quiet cycles catch any extra beat that should not be there
        repeat (4) step(rdy_seen);
        if (exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("timeout: beats were left in the scoreboard at the end");
        end
    end

endmodule

/* video_gray_path.f */
source/video_gray_pkg.sv
source/video_data_pipeline.sv
source/video_rgb2gray_gen.sv
source/video_beat_fork.sv
source/video_beat_join.sv
source/video_gray_path.sv
tb/video_gray_path_checker.sv
tb/video_gray_path_tb.sv

/* Makefile */
SIM := obj_dir/Vvideo_gray_path_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): video_gray_path.f $(shell cat video_gray_path.f)
	verilator --binary --timing --assert --top-module video_gray_path_tb \
		-f video_gray_path.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
